/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/cache_pkg.sv
rtl/icache.sv
rtl/dcache.sv
rtl/cache_arbiter.sv
rtl/periph_bridge.sv
rtl/mem_subsystem.sv
verif/tb_wb_memory.sv
verif/tb_mem_subsystem.sv

/* rtl/bus_pkg.sv */
`include "mem_consts.svh"

package bus_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`ADDR_W-1:0] addr_t;

    // Classic Wishbone master outputs, stb is a copy of cyc
    typedef struct packed {
        logic  cyc;
        logic  we;
        addr_t addr;
        word_t wdata;
    } wb_req_t;

endpackage

/* rtl/cache_arbiter.sv */
`timescale 1ns/10ps

module cache_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::mem_req_t icache_req_i,
    output cache_pkg::mem_rsp_t icache_rsp_o,
    input  cache_pkg::mem_req_t dcache_req_i,
    output cache_pkg::mem_rsp_t dcache_rsp_o,
    output bus_pkg::wb_req_t    bus_req_o,
    input  logic                bus_ack_i,
    input  bus_pkg::word_t      bus_rdata_i
);
    import cache_pkg::*;

    arb_state_e state_q;
    logic       icache_cyc;
    logic       dcache_cyc;

    assign icache_cyc = icache_req_i.rd || icache_req_i.wr;
    assign dcache_cyc = dcache_req_i.rd || dcache_req_i.wr;

    // Fixed priority where the data cache wins a tie
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ARB_IDLE;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (dcache_cyc) begin
                        state_q <= ARB_DCACHE;
                    end else if (icache_cyc) begin
                        state_q <= ARB_ICACHE;
                    end
                end
                ARB_ICACHE: begin
                    if (bus_ack_i) begin
                        state_q <= ARB_IDLE;
                    end
                end
                ARB_DCACHE: begin
                    if (bus_ack_i) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    always_comb begin
        case (state_q)
            ARB_ICACHE: begin
                bus_req_o.cyc   = icache_cyc;
                bus_req_o.we    = icache_req_i.wr;
                bus_req_o.addr  = icache_req_i.addr;
                bus_req_o.wdata = icache_req_i.wdata;
            end
            ARB_DCACHE: begin
                bus_req_o.cyc   = dcache_cyc;
                bus_req_o.we    = dcache_req_i.wr;
                bus_req_o.addr  = dcache_req_i.addr;
                bus_req_o.wdata = dcache_req_i.wdata;
            end
            default: bus_req_o = '0;
        endcase
    end

    assign icache_rsp_o.ack   = bus_ack_i && (state_q == ARB_ICACHE);
    assign icache_rsp_o.rdata = bus_rdata_i;
    assign dcache_rsp_o.ack   = bus_ack_i && (state_q == ARB_DCACHE);
    assign dcache_rsp_o.rdata = bus_rdata_i;

    // The granted cache keeps its request steady until ack
    a_grant_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req_o.cyc && !bus_ack_i |=>
            state_q == $past(state_q) && $stable(bus_req_o));

endmodule

/* rtl/cache_pkg.sv */
`include "mem_consts.svh"

package cache_pkg;

    // Access request, rd and wr are levels held until ack
    typedef struct packed {
        logic           rd;
        logic           wr;
        bus_pkg::addr_t addr;
        bus_pkg::word_t wdata;
    } mem_req_t;

    // Ack is a single-cycle pulse
    typedef struct packed {
        logic           ack;
        bus_pkg::word_t rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        WRITE
    } cache_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ICACHE,
        ARB_DCACHE
    } arb_state_e;

endpackage

/* rtl/dcache.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"

module dcache #(
    parameter int DEPTH = `DCACHE_DEPTH
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::mem_req_t req_i,
    output cache_pkg::mem_rsp_t rsp_o,
    output cache_pkg::mem_req_t mem_req_o,
    input  cache_pkg::mem_rsp_t mem_rsp_i
);
    import bus_pkg::*;
    import cache_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);
    localparam int TAG_W = `ADDR_W - IDX_W - 2;

    logic [TAG_W-1:0] tag_mem [DEPTH];
    word_t            data_mem [DEPTH];
    logic [DEPTH-1:0] valid_q;

    cache_state_e     state_q;
    addr_t            addr_q;
    word_t            wdata_q;
    word_t            rdata_q;
    logic             ack_q;

    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0] fill_tag;
    logic             hit;

    assign req_idx  = req_i.addr[IDX_W+1:2];
    assign req_tag  = req_i.addr[`ADDR_W-1:IDX_W+2];
    assign fill_idx = addr_q[IDX_W+1:2];
    assign fill_tag = addr_q[`ADDR_W-1:IDX_W+2];

    assign hit = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            valid_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (req_i.wr) begin
                        state_q <= WRITE;
                    end else if (req_i.rd) begin
                        if (hit) begin
                            ack_q   <= 1'b1;
                            state_q <= LOOKUP;
                        end else begin
                            state_q <= REFILL;
                        end
                    end
                end
                LOOKUP: state_q <= IDLE;
                REFILL: begin
                    if (mem_rsp_i.ack) begin
                        valid_q[fill_idx] <= 1'b1;
                        ack_q             <= 1'b1;
                        state_q           <= LOOKUP;
                    end
                end
                // Write through, the line is not allocated on a miss
                WRITE: begin
                    if (mem_rsp_i.ack) begin
                        ack_q   <= 1'b1;
                        state_q <= LOOKUP;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            addr_q  <= req_i.addr;
            wdata_q <= req_i.wdata;
            if (req_i.rd && hit) begin
                rdata_q <= data_mem[req_idx];
            end
            // Write hit keeps the line in step with memory
            if (req_i.wr && hit) begin
                data_mem[req_idx] <= req_i.wdata;
            end
        end
        if (state_q == REFILL && mem_rsp_i.ack) begin
            tag_mem[fill_idx]  <= fill_tag;
            data_mem[fill_idx] <= mem_rsp_i.rdata;
            rdata_q            <= mem_rsp_i.rdata;
        end
    end

    assign rsp_o.ack   = ack_q;
    assign rsp_o.rdata = rdata_q;

    assign mem_req_o.rd    = (state_q == REFILL);
    assign mem_req_o.wr    = (state_q == WRITE);
    assign mem_req_o.addr  = addr_q;
    assign mem_req_o.wdata = wdata_q;

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(req_i.rd && req_i.wr));

endmodule

/* rtl/icache.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"

module icache #(
    parameter int DEPTH = `ICACHE_DEPTH
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::mem_req_t req_i,
    input  logic                flush_i,
    output cache_pkg::mem_rsp_t rsp_o,
    output cache_pkg::mem_req_t mem_req_o,
    input  cache_pkg::mem_rsp_t mem_rsp_i
);
    import bus_pkg::*;
    import cache_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);
    localparam int TAG_W = `ADDR_W - IDX_W - 2;

    logic [TAG_W-1:0] tag_mem [DEPTH];
    word_t            data_mem [DEPTH];
    logic [DEPTH-1:0] valid_q;

    cache_state_e     state_q;
    addr_t            addr_q;
    word_t            rdata_q;
    logic             ack_q;
    logic             cancel_q;
    logic             cancel;

    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0] fill_tag;
    logic             hit;

    // Word address split into index and tag
    assign req_idx  = req_i.addr[IDX_W+1:2];
    assign req_tag  = req_i.addr[`ADDR_W-1:IDX_W+2];
    assign fill_idx = addr_q[IDX_W+1:2];
    assign fill_tag = addr_q[`ADDR_W-1:IDX_W+2];

    assign hit    = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign cancel = cancel_q || flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            valid_q  <= '0;
            ack_q    <= 1'b0;
            cancel_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    cancel_q <= 1'b0;
                    if (req_i.rd && !flush_i) begin
                        if (hit) begin
                            ack_q   <= 1'b1;
                            state_q <= LOOKUP;
                        end else begin
                            state_q <= REFILL;
                        end
                    end
                end
                // Ack cycle while the fetch port still shows the old request
                LOOKUP: state_q <= IDLE;
                REFILL: begin
                    if (flush_i) begin
                        cancel_q <= 1'b1;
                    end
                    if (mem_rsp_i.ack) begin
                        valid_q[fill_idx] <= 1'b1;
                        ack_q             <= !cancel;
                        state_q           <= cancel ? IDLE : LOOKUP;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            addr_q <= req_i.addr;
            if (hit) begin
                rdata_q <= data_mem[req_idx];
            end
        end
        // Line fill is done even for a cancelled fetch
        if (state_q == REFILL && mem_rsp_i.ack) begin
            tag_mem[fill_idx]  <= fill_tag;
            data_mem[fill_idx] <= mem_rsp_i.rdata;
            rdata_q            <= mem_rsp_i.rdata;
        end
    end

    assign rsp_o.ack   = ack_q;
    assign rsp_o.rdata = rdata_q;

    assign mem_req_o.rd    = (state_q == REFILL);
    assign mem_req_o.wr    = 1'b0;
    assign mem_req_o.addr  = addr_q;
    assign mem_req_o.wdata = '0;

    // A memory ack only answers the pending refill read
    a_ack_on_refill_read: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_i.ack |-> mem_req_o.rd && !mem_req_o.wr);

endmodule

/* rtl/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Bus widths
`define WORD_W 32
`define ADDR_W 32

// Cache sizes in one-word lines, power of two
`define ICACHE_DEPTH 32
`define DCACHE_DEPTH 32

// Data accesses with this address bit set bypass the data cache
`define PERIPH_BIT 31

`endif

/* rtl/mem_subsystem.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_subsystem (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::mem_req_t ifetch_req_i,
    input  logic                ifetch_flush_i,
    output cache_pkg::mem_rsp_t ifetch_rsp_o,
    input  cache_pkg::mem_req_t data_req_i,
    output cache_pkg::mem_rsp_t data_rsp_o,
    output bus_pkg::wb_req_t    wb_o,
    output logic                stb_o,
    input  logic                ack_i,
    input  bus_pkg::word_t      rdata_i
);
    import bus_pkg::*;
    import cache_pkg::*;

    mem_req_t icache_mem_req;
    mem_rsp_t icache_mem_rsp;
    mem_req_t dcache_core_req;
    mem_rsp_t dcache_core_rsp;
    mem_req_t dcache_mem_req;
    mem_rsp_t dcache_mem_rsp;
    wb_req_t  arb_req;
    logic     arb_ack;

    icache #(
        .DEPTH (`ICACHE_DEPTH)
    ) u_icache (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (ifetch_req_i),
        .flush_i   (ifetch_flush_i),
        .rsp_o     (ifetch_rsp_o),
        .mem_req_o (icache_mem_req),
        .mem_rsp_i (icache_mem_rsp)
    );

    dcache #(
        .DEPTH (`DCACHE_DEPTH)
    ) u_dcache (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (dcache_core_req),
        .rsp_o     (dcache_core_rsp),
        .mem_req_o (dcache_mem_req),
        .mem_rsp_i (dcache_mem_rsp)
    );

    cache_arbiter u_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .icache_req_i (icache_mem_req),
        .icache_rsp_o (icache_mem_rsp),
        .dcache_req_i (dcache_mem_req),
        .dcache_rsp_o (dcache_mem_rsp),
        .bus_req_o    (arb_req),
        .bus_ack_i    (arb_ack),
        .bus_rdata_i  (rdata_i)
    );

    // Owns the Wishbone port, the arbiter only sees ack when it is master
    periph_bridge u_bridge (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_req_i   (data_req_i),
        .core_rsp_o   (data_rsp_o),
        .dcache_req_o (dcache_core_req),
        .dcache_rsp_i (dcache_core_rsp),
        .arb_req_i    (arb_req),
        .arb_ack_o    (arb_ack),
        .wb_o         (wb_o),
        .stb_o        (stb_o),
        .ack_i        (ack_i),
        .rdata_i      (rdata_i)
    );

endmodule

/* rtl/periph_bridge.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"

module periph_bridge (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::mem_req_t core_req_i,
    output cache_pkg::mem_rsp_t core_rsp_o,
    output cache_pkg::mem_req_t dcache_req_o,
    input  cache_pkg::mem_rsp_t dcache_rsp_i,
    input  bus_pkg::wb_req_t    arb_req_i,
    output logic                arb_ack_o,
    output bus_pkg::wb_req_t    wb_o,
    output logic                stb_o,
    input  logic                ack_i,
    input  bus_pkg::word_t      rdata_i
);
    import bus_pkg::*;

    logic  periph_addr;
    logic  periph_req;
    logic  periph_own;
    logic  lock_q;
    logic  wr_through_q;
    logic  arb_hold_q;
    logic  periph_ack_q;
    word_t periph_rdata_q;

    assign periph_addr = core_req_i.addr[`PERIPH_BIT];
    // Masked in the ack cycle since the core still shows the finished request
    assign periph_req  = periph_addr && (core_req_i.rd || core_req_i.wr) && !periph_ack_q;
    // An arbiter cycle already on the bus is not cut off
    assign periph_own  = lock_q || (periph_req && !arb_hold_q);

    always_comb begin
        dcache_req_o    = core_req_i;
        dcache_req_o.rd = core_req_i.rd && !periph_addr;
        dcache_req_o.wr = core_req_i.wr && !periph_addr;
    end

    always_comb begin
        if (periph_own) begin
            wb_o.cyc   = 1'b1;
            wb_o.we    = core_req_i.wr || wr_through_q;
            wb_o.addr  = core_req_i.addr;
            wb_o.wdata = core_req_i.wdata;
        end else begin
            wb_o = arb_req_i;
        end
    end

    assign stb_o     = wb_o.cyc;
    assign arb_ack_o = ack_i && !periph_own;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lock_q       <= 1'b0;
            wr_through_q <= 1'b0;
            arb_hold_q   <= 1'b0;
            periph_ack_q <= 1'b0;
        end else begin
            if (periph_own && !ack_i) begin
                lock_q       <= 1'b1;
                wr_through_q <= core_req_i.wr || wr_through_q;
            end else if (ack_i) begin
                lock_q       <= 1'b0;
                wr_through_q <= 1'b0;
            end
            arb_hold_q   <= !periph_own && arb_req_i.cyc && !ack_i;
            periph_ack_q <= periph_own && ack_i;
        end
    end

    always_ff @(posedge clk) begin
        if (periph_own && ack_i) begin
            periph_rdata_q <= rdata_i;
        end
    end

    assign core_rsp_o.ack   = periph_ack_q || dcache_rsp_i.ack;
    assign core_rsp_o.rdata = periph_ack_q ? periph_rdata_q : dcache_rsp_i.rdata;

    // A pending arbiter cycle stays on the bus unchanged and never under the lock
    a_no_lock_under_arb: assert property (@(posedge clk) disable iff (!rst_n)
        !periph_own && arb_req_i.cyc && !ack_i |=> !lock_q && $stable(wb_o));

endmodule

/* verif/tb_mem_subsystem.sv */
`timescale 1ns/10ps

module tb_mem_subsystem;
    import bus_pkg::*;
    import cache_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int WORST_OP_CYCLS = 40;

    typedef enum {
        OP_FETCH,
        OP_FETCH_HIT,
        OP_LOAD,
        OP_LOAD_HIT,
        OP_STORE,
        OP_DUAL,
        OP_FLUSH
    } op_kind_e;

    typedef struct {
        op_kind_e kind;
        addr_t    addr;
        addr_t    addr2;
        word_t    wdata;
        word_t    exp;
        word_t    exp2;
        int       delta;
    } op_t;

    logic        clk;
    logic        rst_n;
    mem_req_t    ifetch_req;
    logic        ifetch_flush;
    mem_rsp_t    ifetch_rsp;
    mem_req_t    data_req;
    mem_rsp_t    data_rsp;
    wb_req_t     wb;
    logic        stb;
    logic        ack;
    word_t       rdata;
    int unsigned bus_cycles;

    op_t         ops[$];
    addr_t       ack_addrs[$];
    addr_t       last_wr_addr;
    word_t       last_wr_data;
    logic        table_ready;

    mem_subsystem uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .ifetch_req_i   (ifetch_req),
        .ifetch_flush_i (ifetch_flush),
        .ifetch_rsp_o   (ifetch_rsp),
        .data_req_i     (data_req),
        .data_rsp_o     (data_rsp),
        .wb_o           (wb),
        .stb_o          (stb),
        .ack_i          (ack),
        .rdata_i        (rdata)
    );

    tb_wb_memory u_memory (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_i     (wb),
        .stb_i    (stb),
        .ack_o    (ack),
        .rdata_o  (rdata),
        .cycles_o (bus_cycles)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Bus monitor records the order of finished cycles and the last write
    always @(negedge clk) begin
        if (wb.cyc && ack) begin
            ack_addrs.push_back(wb.addr);
            if (wb.we) begin
                last_wr_addr = wb.addr;
                last_wr_data = wb.wdata;
            end
        end
    end

    function automatic word_t init_word(addr_t addr);
        return {2'b00, addr[31:2]} ^ 32'hA5A5_0000;
    endfunction

    function automatic mem_req_t build_request(logic rd, logic wr, addr_t addr, word_t wdata);
        mem_req_t req;
        req.rd    = rd;
        req.wr    = wr;
        req.addr  = addr;
        req.wdata = wdata;
        return req;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic add_op(op_kind_e kind, addr_t addr, addr_t addr2, word_t wdata,
                          word_t exp, word_t exp2, int delta);
        op_t op;
        op.kind  = kind;
        op.addr  = addr;
        op.addr2 = addr2;
        op.wdata = wdata;
        op.exp   = exp;
        op.exp2  = exp2;
        op.delta = delta;
        ops.push_back(op);
    endtask

    // One request on one port held until its ack
    task automatic single_access(logic fetch, logic wr, addr_t addr, word_t wdata,
                                 output word_t data, output int latency);
        logic got_ack;
        @(posedge clk);
        if (fetch) begin
            ifetch_req <= build_request(1'b1, 1'b0, addr, '0);
        end else begin
            data_req <= build_request(!wr, wr, addr, wdata);
        end
        latency = 0;
        got_ack = 1'b0;
        while (!got_ack) begin
            @(negedge clk);
            latency++;
            got_ack = fetch ? ifetch_rsp.ack : data_rsp.ack;
        end
        data = fetch ? ifetch_rsp.rdata : data_rsp.rdata;
        @(posedge clk);
        ifetch_req <= '0;
        data_req   <= '0;
    endtask

    task automatic dual_access(addr_t faddr, addr_t daddr, output word_t fdata,
                               output word_t ddata);
        logic f_done;
        logic d_done;
        f_done = 1'b0;
        d_done = 1'b0;
        @(posedge clk);
        ifetch_req <= build_request(1'b1, 1'b0, faddr, '0);
        data_req   <= build_request(1'b1, 1'b0, daddr, '0);
        while (!(f_done && d_done)) begin
            @(negedge clk);
            if (!f_done && ifetch_rsp.ack) begin
                f_done = 1'b1;
                fdata  = ifetch_rsp.rdata;
            end
            if (!d_done && data_rsp.ack) begin
                d_done = 1'b1;
                ddata  = data_rsp.rdata;
            end
            @(posedge clk);
            if (f_done) ifetch_req <= '0;
            if (d_done) data_req <= '0;
        end
    endtask

    // Fetch miss cancelled while the refill is on the bus
    task automatic flushed_fetch(addr_t addr, int unsigned base);
        @(posedge clk);
        ifetch_req <= build_request(1'b1, 1'b0, addr, '0);
        @(posedge clk);
        ifetch_req   <= '0;
        ifetch_flush <= 1'b1;
        @(posedge clk);
        ifetch_flush <= 1'b0;
        while (bus_cycles == base) begin
            @(negedge clk);
            check_value("ifetch_rsp.ack", {31'b0, ifetch_rsp.ack}, 32'd0);
        end
        repeat (3) begin
            @(negedge clk);
            check_value("ifetch_rsp.ack", {31'b0, ifetch_rsp.ack}, 32'd0);
        end
    endtask

    task automatic run_op(op_t op);
        int unsigned base;
        int          first_ack;
        int          latency;
        word_t       data;
        word_t       data2;
        base      = bus_cycles;
        first_ack = ack_addrs.size();
        case (op.kind)
            OP_FETCH, OP_FETCH_HIT, OP_LOAD, OP_LOAD_HIT: begin
                single_access(op.kind == OP_FETCH || op.kind == OP_FETCH_HIT, 1'b0,
                              op.addr, '0, data, latency);
                check_value("rdata", data, op.exp);
                if (op.kind == OP_FETCH_HIT || op.kind == OP_LOAD_HIT) begin
                    // Sampled at the first edge so the ack shows right after the next one
                    check_value("hit latency", latency, 32'd2);
                end
            end
            OP_STORE: begin
                single_access(1'b0, 1'b1, op.addr, op.wdata, data, latency);
                check_value("wb write addr", last_wr_addr, op.addr);
                check_value("wb write data", last_wr_data, op.wdata);
            end
            OP_DUAL: begin
                dual_access(op.addr, op.addr2, data, data2);
                check_value("fetch rdata", data, op.exp);
                check_value("load rdata", data2, op.exp2);
                check_value("first bus addr", ack_addrs[first_ack], op.addr2);
            end
            default: flushed_fetch(op.addr, base);
        endcase
        check_value("bus cycle delta", bus_cycles - base, op.delta);
    endtask

    initial begin
        wait (table_ready);
        #(WORST_OP_CYCLS * (ops.size() + 2) * CLK_PERIOD);
        $display("=== FAIL ===");
        $fatal(1, "Timeout, the DUT stopped answering");
    end

    initial begin
        rst_n        = 1'b0;
        ifetch_req   = '0;
        ifetch_flush = 1'b0;
        data_req     = '0;
        table_ready  = 1'b0;
        last_wr_addr = '0;
        last_wr_data = '0;

        add_op(OP_FETCH,     32'h0000_0100, '0, '0, init_word(32'h100), '0, 1);
        add_op(OP_FETCH_HIT, 32'h0000_0100, '0, '0, init_word(32'h100), '0, 0);
        add_op(OP_LOAD,      32'h0000_0200, '0, '0, init_word(32'h200), '0, 1);
        add_op(OP_STORE,     32'h0000_0200, '0, 32'h1234_5678, '0, '0, 1);
        add_op(OP_LOAD_HIT,  32'h0000_0200, '0, '0, 32'h1234_5678, '0, 0);
        add_op(OP_STORE,     32'h8000_0040, '0, 32'hDEAD_BEEF, '0, '0, 1);
        add_op(OP_LOAD,      32'h8000_0040, '0, '0, 32'hDEAD_BEEF, '0, 1);
        add_op(OP_LOAD,      32'h8000_0040, '0, '0, 32'hDEAD_BEEF, '0, 1);
        add_op(OP_LOAD,      32'h8000_0044, '0, '0, 32'hC0DE_0044, '0, 1);
        add_op(OP_LOAD,      32'h8000_0044, '0, '0, 32'hC0DE_0044, '0, 1);
        add_op(OP_DUAL,      32'h0000_0300, 32'h0000_0400, '0,
               init_word(32'h300), init_word(32'h400), 2);
        add_op(OP_FLUSH,     32'h0000_0500, '0, '0, '0, '0, 1);
        add_op(OP_FETCH_HIT, 32'h0000_0500, '0, '0, init_word(32'h500), '0, 0);
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Idle bus after reset
        repeat (4) begin
            @(negedge clk);
            check_value("cyc_o", {31'b0, wb.cyc}, 32'd0);
            check_value("stb_o", {31'b0, stb}, 32'd0);
        end

        foreach (ops[i]) begin
            run_op(ops[i]);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* verif/tb_wb_memory.sv */
`timescale 1ns/10ps

module tb_wb_memory (
    input  logic             clk,
    input  logic             rst_n,
    input  bus_pkg::wb_req_t wb_i,
    input  logic             stb_i,
    output logic             ack_o,
    output bus_pkg::word_t   rdata_o,
    output int unsigned      cycles_o
);
    import bus_pkg::*;

    // Only written words are stored, everything else follows the fill pattern
    word_t       written [addr_t];
    logic [31:0] lfsr_q = 32'h3915_8f03;
    logic        busy;
    logic [1:0]  wait_cnt;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_q[0];
        lfsr_q  = lfsr_q >> 1;
        if (out_bit) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    function automatic word_t read_word(addr_t addr);
        addr_t key;
        key = {addr[31:2], 2'b00};
        if (written.exists(key)) begin
            return written[key];
        end
        if (addr[31]) begin
            return 32'hC0DE_0000 + {16'h0000, addr[15:0]};
        end
        return {2'b00, addr[31:2]} ^ 32'hA5A5_0000;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            ack_o    <= 1'b0;
            cycles_o <= 0;
            busy     = 1'b0;
        end else begin
            ack_o <= 1'b0;
            if (wb_i.cyc && stb_i && !ack_o) begin
                if (!busy) begin
                    busy     = 1'b1;
                    wait_cnt = {next_random_bit(), next_random_bit()};
                end
                if (wait_cnt == 2'd0) begin
                    busy     = 1'b0;
                    ack_o    <= 1'b1;
                    cycles_o <= cycles_o + 1;
                    if (wb_i.we) begin
                        written[{wb_i.addr[31:2], 2'b00}] = wb_i.wdata;
                    end else begin
                        rdata_o <= read_word(wb_i.addr);
                    end
                end else begin
                    wait_cnt = wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule
